// ==== x86_predec_consts.svh ====
// Predecoder constants: window size, prefix limit and the recognised byte values
`ifndef X86_PREDEC_CONSTS_SVH
`define X86_PREDEC_CONSTS_SVH

// Bytes seen per instruction window
`define PREDEC_WINDOW_BYTES 6

// Longest legacy prefix chain that is decoded
`define PREDEC_MAX_PREFIX 3

// Operand size override
`define BYTE_OPSIZE 8'h66

// REPNE
`define BYTE_REPNE 8'hF2

// Segment overrides
`define BYTE_SEG_CS 8'h2E
`define BYTE_SEG_SS 8'h36
`define BYTE_SEG_DS 8'h3E
`define BYTE_SEG_ES 8'h26
`define BYTE_SEG_FS 8'h64
`define BYTE_SEG_GS 8'h65

// Two-byte opcode escape
`define BYTE_ESCAPE 8'h0F

`endif

// ==== x86_predec_pkg.sv ====
// Predecoder shared types: window, prefix and immediate kinds, stage and result structs
`include "x86_predec_consts.svh"

package x86_predec_pkg;

	// Byte 0 is the first byte of the instruction
	typedef logic [`PREDEC_WINDOW_BYTES-1:0][7:0] window_t;

	typedef enum logic [1:0] {
		PFX_NONE,
		PFX_OPSIZE,
		PFX_SEG,
		PFX_REPNE
	} prefix_kind_e;

	typedef enum logic [1:0] {
		IMM_NONE,
		IMM8,
		IMM16,
		IMM32
	} imm_kind_e;

	typedef struct packed {
		logic [1:0] prefix_count;
		logic       has_opsize;
		logic       has_seg;
		logic       has_repne;
		logic [7:0] seg_byte;
	} prefix_info_t;

	typedef struct packed {
		logic [7:0] opcode;
		logic       two_byte;
		logic [7:0] op_ext;
		// No ModRM possible after a full prefix chain
		logic       modrm_allowed;
		logic [7:0] modrm;
		logic [7:0] sib;
	} opcode_info_t;

	// Stage 1 to stage 2 register
	typedef struct packed {
		prefix_info_t prefixes;
		opcode_info_t opcode_info;
	} stage1_t;

	typedef struct packed {
		prefix_info_t prefixes;
		logic [7:0]   opcode;
		logic         two_byte;
		logic [7:0]   op_ext;
		logic         has_modrm;
		logic [7:0]   modrm;
		logic [7:0]   sib;
		logic         has_sib;
		logic         has_disp8;
		logic         has_disp32;
		imm_kind_e    imm;
	} predec_result_t;

endpackage

// ==== prefix_scan.sv ====
// Legacy prefix chain scan: prefix count, prefix flags and segment override byte
`timescale 1ns/100ps
`include "x86_predec_consts.svh"

module prefix_scan import x86_predec_pkg::*; (
	input  window_t      window,
	output prefix_info_t prefixes
);

	prefix_kind_e kind [`PREDEC_MAX_PREFIX];

	function automatic prefix_kind_e classify(input logic [7:0] b);
		case (b)
			`BYTE_OPSIZE: return PFX_OPSIZE;
			`BYTE_REPNE:  return PFX_REPNE;
			`BYTE_SEG_CS, `BYTE_SEG_SS, `BYTE_SEG_DS,
			`BYTE_SEG_ES, `BYTE_SEG_FS, `BYTE_SEG_GS: return PFX_SEG;
			default:      return PFX_NONE;
		endcase
	endfunction

	always_comb begin
		for (int i = 0; i < `PREDEC_MAX_PREFIX; i++) begin
			kind[i] = classify(window[i]);
		end
	end

	// A byte counts only while every earlier byte was a prefix too
	always_comb begin
		logic chain;
		prefixes = '0;
		chain = 1'b1;
		for (int i = 0; i < `PREDEC_MAX_PREFIX; i++) begin
			chain = chain && (kind[i] != PFX_NONE);
			if (chain) begin
				prefixes.prefix_count = prefixes.prefix_count + 2'd1;
				case (kind[i])
					PFX_OPSIZE: prefixes.has_opsize = 1'b1;
					PFX_REPNE:  prefixes.has_repne = 1'b1;
					PFX_SEG: begin
						prefixes.has_seg = 1'b1;
						// Several overrides merge bitwise
						prefixes.seg_byte = prefixes.seg_byte | window[i];
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== opcode_locate.sv ====
// Opcode locator: opcode byte, 0F escape, extension byte, ModRM and SIB byte selection
`timescale 1ns/100ps
`include "x86_predec_consts.svh"

module opcode_locate import x86_predec_pkg::*; (
	input  window_t      window,
	input  prefix_info_t prefixes,
	output opcode_info_t opcode_info
);

	logic [2:0] opc_idx;
	logic [2:0] modrm_idx;
	logic [2:0] sib_idx;
	logic       escape;

	// Opcode sits right after the counted prefixes
	assign opc_idx = 3'(prefixes.prefix_count);
	assign escape = (window[opc_idx] == `BYTE_ESCAPE);

	// ModRM follows the opcode, one byte later again after an escape
	assign modrm_idx = opc_idx + 3'd1 + 3'(escape);
	assign sib_idx = modrm_idx + 3'd1;

	always_comb begin
		opcode_info.opcode = window[opc_idx];
		opcode_info.two_byte = escape;
		opcode_info.op_ext = escape ? window[opc_idx + 3'd1] : 8'h00;
		opcode_info.modrm_allowed = (prefixes.prefix_count < `PREDEC_MAX_PREFIX);
		opcode_info.modrm = window[modrm_idx];
		// SIB slot can run past the end of the window
		if (sib_idx < `PREDEC_WINDOW_BYTES) begin
			opcode_info.sib = window[sib_idx];
		end else begin
			opcode_info.sib = 8'h00;
		end
	end

endmodule

// ==== opcode_tables.sv ====
// Opcode tables: ModRM presence and immediate size per opcode
`timescale 1ns/100ps

module opcode_tables import x86_predec_pkg::*; (
	input  opcode_info_t opcode_info,
	input  logic         has_opsize,
	output logic         has_modrm,
	output imm_kind_e    imm
);

	logic modrm_hit;
	logic imm8_hit;
	logic full_hit;
	logic imm16_hit;

	always_comb begin
		modrm_hit = 1'b0;
		if (opcode_info.two_byte) begin
			case (opcode_info.op_ext)
				8'h42, 8'h6F, 8'h70, 8'h7F, 8'hB0, 8'hB1,
				8'hED, 8'hFD, 8'hFE: modrm_hit = 1'b1;
				default: modrm_hit = 1'b0;
			endcase
		end else begin
			case (opcode_info.opcode) inside
				[8'h00:8'h03], [8'h08:8'h0B], [8'h20:8'h23],
				8'h80, 8'h81, 8'h83, [8'h86:8'h8C], 8'h8E, 8'h8F,
				8'hC0, 8'hC1, 8'hC6, 8'hC7, [8'hD0:8'hD3],
				8'hF6, 8'hF7, 8'hFE, 8'hFF: modrm_hit = 1'b1;
				default: modrm_hit = 1'b0;
			endcase
		end
	end

	assign has_modrm = modrm_hit && opcode_info.modrm_allowed;

	always_comb begin
		imm8_hit = 1'b0;
		full_hit = 1'b0;
		imm16_hit = 1'b0;
		if (opcode_info.two_byte) begin
			case (opcode_info.op_ext)
				// PSHUFW
				8'h70: imm8_hit = 1'b1;
				// Near Jcc rel
				8'h85, 8'h87: full_hit = 1'b1;
				default: ;
			endcase
		end else begin
			case (opcode_info.opcode) inside
				8'h04, 8'h0C, 8'h24, 8'h6A, 8'h75, 8'h77, 8'h80, 8'h83,
				[8'hB0:8'hB7], 8'hC0, 8'hC1, 8'hC6, 8'hEB: imm8_hit = 1'b1;
				8'h05, 8'h0D, 8'h25, 8'h68, 8'h81, [8'hB8:8'hBF],
				8'hC7, 8'hE8, 8'hE9: full_hit = 1'b1;
				// RET imm16 ignores operand size
				8'hC2, 8'hCA: imm16_hit = 1'b1;
				default: ;
			endcase
		end
	end

	always_comb begin
		if (imm8_hit) begin
			imm = IMM8;
		end else if (imm16_hit || (full_hit && has_opsize)) begin
			imm = IMM16;
		end else if (full_hit) begin
			imm = IMM32;
		end else begin
			imm = IMM_NONE;
		end
	end

endmodule

// ==== modrm_fields.sv ====
// ModRM field decode: SIB and displacement needs
`timescale 1ns/100ps

module modrm_fields (
	input  logic [7:0] modrm,
	input  logic       has_modrm,
	output logic       has_sib,
	output logic       has_disp8,
	output logic       has_disp32
);

	logic [1:0] mod_f;
	logic [2:0] rm_f;

	assign mod_f = modrm[7:6];
	assign rm_f = modrm[2:0];

	// SIB escape through rm 100 on memory forms
	assign has_sib = has_modrm && (rm_f == 3'b100) && (mod_f != 2'b11);

	assign has_disp8 = has_modrm && (mod_f == 2'b01);

	// mod 00 rm 101 is plain disp32 addressing
	assign has_disp32 = has_modrm &&
		((mod_f == 2'b10) || ((mod_f == 2'b00) && (rm_f == 3'b101)));

endmodule

// ==== x86_predec_top.sv ====
// Predecoder top: two pipeline stages, valid/ready stream handshake and decode instances
`timescale 1ns/100ps

module x86_predec_top import x86_predec_pkg::*; (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           in_valid,
	output logic           in_ready,
	input  window_t        in_window,
	output logic           out_valid,
	input  logic           out_ready,
	output predec_result_t out_result
);

	prefix_info_t   prefixes;
	opcode_info_t   opcode_info;
	stage1_t        s1_q;
	logic           s1_valid;
	logic           advance;
	logic           has_modrm;
	logic           has_sib;
	logic           has_disp8;
	logic           has_disp32;
	imm_kind_e      imm;
	predec_result_t result_d;

	// Whole pipeline moves or holds as one
	assign advance = !out_valid || out_ready;
	assign in_ready = advance;

	// Stage 1
	prefix_scan u_prefix_scan (
		.window   (in_window),
		.prefixes (prefixes)
	);

	opcode_locate u_opcode_locate (
		.window      (in_window),
		.prefixes    (prefixes),
		.opcode_info (opcode_info)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= in_valid;
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && in_valid) begin
			s1_q.prefixes <= prefixes;
			s1_q.opcode_info <= opcode_info;
		end
	end

	// Stage 2
	opcode_tables u_opcode_tables (
		.opcode_info (s1_q.opcode_info),
		.has_opsize  (s1_q.prefixes.has_opsize),
		.has_modrm   (has_modrm),
		.imm         (imm)
	);

	modrm_fields u_modrm_fields (
		.modrm      (s1_q.opcode_info.modrm),
		.has_modrm  (has_modrm),
		.has_sib    (has_sib),
		.has_disp8  (has_disp8),
		.has_disp32 (has_disp32)
	);

	always_comb begin
		result_d.prefixes = s1_q.prefixes;
		result_d.opcode = s1_q.opcode_info.opcode;
		result_d.two_byte = s1_q.opcode_info.two_byte;
		result_d.op_ext = s1_q.opcode_info.op_ext;
		result_d.has_modrm = has_modrm;
		result_d.modrm = s1_q.opcode_info.modrm;
		result_d.sib = s1_q.opcode_info.sib;
		result_d.has_sib = has_sib;
		result_d.has_disp8 = has_disp8;
		result_d.has_disp32 = has_disp32;
		result_d.imm = imm;
	end

	// Held under back-pressure since advance is low
	always_ff @(posedge clk) begin
		if (advance && s1_valid) begin
			out_result <= result_d;
		end
	end

endmodule

// ==== x86_predec_sva.sv ====
// Bound assertions on the predecoder output stream and result fields
`timescale 1ns/100ps

module x86_predec_sva import x86_predec_pkg::*; (
	input logic           clk,
	input logic           arst_n,
	input logic           out_valid,
	input logic           out_ready,
	input predec_result_t out_result
);

	// A stalled result holds still
	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> $stable(out_result))
		else $error("out_result changed while stalled");

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !out_result.has_sib || out_result.has_modrm)
		else $error("has_sib set without has_modrm");

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !(out_result.has_disp8 && out_result.has_disp32))
		else $error("has_disp8 and has_disp32 both set");

	assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

endmodule

bind x86_predec_top x86_predec_sva sva0 (.*);

// ==== tb_x86_predec_tests.svh ====
// Directed tests: prefix chains, 0F escape, ModRM fields, immediate table and streaming

// Immediate table as {size without 66, 0F escape, opcode byte}
localparam logic [10:0] IMM_OPS [41] = '{
	11'h204, 11'h20C, 11'h224, 11'h26A, 11'h275, 11'h277, 11'h280, 11'h283,
	11'h2B0, 11'h2B1, 11'h2B2, 11'h2B3, 11'h2B4, 11'h2B5, 11'h2B6, 11'h2B7,
	11'h2C0, 11'h2C1, 11'h2C6, 11'h2EB, 11'h370, 11'h4C2, 11'h4CA,
	11'h605, 11'h60D, 11'h625, 11'h668, 11'h681, 11'h6B8, 11'h6B9, 11'h6BA,
	11'h6BB, 11'h6BC, 11'h6BD, 11'h6BE, 11'h6BF, 11'h6C7, 11'h6E8, 11'h6E9,
	11'h785, 11'h787};

// Every chain of 66, 2E and F2 up to three long, then 90
task automatic prefix_chains();
	logic [7:0] pfx [3] = '{`BYTE_OPSIZE, `BYTE_SEG_CS, `BYTE_REPNE};
	window_t w;
	predec_result_t r;
	logic [2:0] seen;
	int code;
	for (int n = 0; n <= 3; n++) begin
		for (int c = 0; c < 3 ** n; c++) begin
			w = {6{8'h90}};
			seen = '0;
			code = c;
			for (int i = 0; i < n; i++) begin
				w[i] = pfx[code % 3];
				seen[code % 3] = 1'b1;
				code = code / 3;
			end
			apply_window(w, r);
			compare("prefixes", r.prefixes,
				{2'(n), seen[0], seen[1], seen[2], seen[1] ? `BYTE_SEG_CS : 8'h00});
			compare("opcode", r.opcode, 8'h90);
		end
	end
	// Byte 0 is rightmost; prefixes after 90 are not counted
	apply_window({8'h90, 8'h90, 8'hF2, 8'h2E, 8'h66, 8'h90}, r);
	compare("prefixes", r.prefixes, 13'h0);
	apply_window({8'h90, 8'h90, 8'h90, 8'h2E, 8'h90, 8'h66}, r);
	compare("prefixes", r.prefixes, {2'd1, 1'b1, 1'b0, 1'b0, 8'h00});
endtask

// Zero to three 2E prefixes then 0F 85, and once more behind 66
task automatic escape_handling();
	window_t w;
	predec_result_t r;
	for (int n = 0; n <= 4; n++) begin
		w = '0;
		for (int i = 0; i < n % 4; i++) begin
			w[i] = `BYTE_SEG_CS;
		end
		if (n == 4) begin
			w[0] = `BYTE_OPSIZE;
		end
		w[(n == 4) ? 1 : n] = `BYTE_ESCAPE;
		w[(n == 4) ? 2 : n + 1] = 8'h85;
		apply_window(w, r);
		compare("two_byte", r.two_byte, 1'b1);
		compare("op_ext", r.op_ext, 8'h85);
		compare("imm", r.imm, (n == 4) ? IMM16 : IMM32);
	end
endtask

// 89, 8B and 0F 6F over every mod with rm 100 and 101
task automatic modrm_decode();
	logic [7:0] ops [3] = '{8'h89, 8'h8B, 8'h6F};
	window_t w;
	predec_result_t r;
	logic [7:0] modrm;
	logic [7:0] sib;
	logic [1:0] md;
	for (int o = 0; o < 3; o++) begin
		for (int m = 0; m < 8; m++) begin
			md = 2'(m >> 1);
			modrm = {md, 3'($urandom_range(7, 0)), 2'b10, m[0]};
			sib = 8'($urandom);
			w = {24'h0, sib, modrm, ops[o]};
			if (o == 2) begin
				w = {16'h0, sib, modrm, ops[o], `BYTE_ESCAPE};
			end
			apply_window(w, r);
			compare("has_modrm/modrm/sib", {r.has_modrm, r.modrm, r.sib}, {1'b1, modrm, sib});
			compare("has_sib/has_disp8/has_disp32", {r.has_sib, r.has_disp8, r.has_disp32},
				{md != 2'b11 && !m[0], md == 2'b01, md == 2'b10 || (md == 2'b00 && m[0])});
		end
	end
	// Full prefix chain leaves no room for ModRM
	apply_window({8'h00, 8'h44, 8'h89, `BYTE_REPNE, `BYTE_SEG_CS, `BYTE_OPSIZE}, r);
	compare("has_modrm/has_sib/has_disp8/has_disp32",
		{r.has_modrm, r.has_sib, r.has_disp8, r.has_disp32}, 4'h0);
endtask

function automatic logic is_listed(input logic [7:0] op);
	logic hit;
	hit = op inside {`BYTE_OPSIZE, `BYTE_REPNE, `BYTE_SEG_CS, `BYTE_SEG_SS, `BYTE_SEG_DS,
		`BYTE_SEG_ES, `BYTE_SEG_FS, `BYTE_SEG_GS, `BYTE_ESCAPE};
	foreach (IMM_OPS[i]) begin
		hit = hit || (IMM_OPS[i][8:0] == {1'b0, op});
	end
	return hit;
endfunction

// Operand size shrinks a full-size immediate to IMM16 and leaves the rest
task automatic imm_pair(input logic [8:0] op, input imm_kind_e plain);
	window_t w;
	predec_result_t r;
	for (int p = 0; p < 2; p++) begin
		w = '0;
		w[0] = `BYTE_OPSIZE;
		w[p] = op[8] ? `BYTE_ESCAPE : op[7:0];
		w[p + 1] = op[8] ? op[7:0] : 8'h00;
		apply_window(w, r);
		compare("imm", r.imm, (p == 1 && plain == IMM32) ? IMM16 : plain);
	end
endtask

task automatic immediate_table();
	logic [7:0] other;
	foreach (IMM_OPS[i]) begin
		imm_pair(IMM_OPS[i][8:0], imm_kind_e'(IMM_OPS[i][10:9]));
	end
	do begin
		other = 8'($urandom);
	end while (is_listed(other));
	imm_pair({1'b0, other}, IMM_NONE);
endtask

// Random windows under random back-pressure, results checked in input order
task automatic stream_backpressure();
	window_t pending [$];
	window_t w;
	int sent;
	int got;
	logic fire;
	sent = 0;
	got = 0;
	fire = 1'b0;
	while (got < STREAM_LEN) begin
		@(negedge clk);
		out_ready = 1'($urandom);
		if (fire) begin
			in_valid = 1'b0;
		end
		if (!in_valid && sent < STREAM_LEN) begin
			// Tag opcode stays clear of prefixes, the index sits in the ModRM slot
			w = 48'({$urandom, $urandom});
			w[0] = 8'h40 + 8'(sent % 32);
			w[1] = 8'(sent);
			in_window = w;
			in_valid = 1'b1;
		end
		#1;
		if (out_valid && out_ready) begin
			compare("result without a pending input", pending.size() == 0, 1'b0);
			w = pending.pop_front();
			compare("prefix_count/opcode/modrm/sib", {out_result.prefixes.prefix_count,
				out_result.opcode, out_result.modrm, out_result.sib}, {2'd0, w[0], w[1], w[2]});
			got++;
		end
		fire = in_valid && in_ready;
		if (fire) begin
			pending.push_back(in_window);
			sent++;
		end
	end
endtask

// ==== tb_x86_predec.sv ====
// Predecoder testbench top: clock, reset, DUT, value check, timeout and final verdict
`timescale 1ns/100ps
`include "x86_predec_consts.svh"

module tb_x86_predec import x86_predec_pkg::*; ();

	// 42 prefix, 5 escape, 25 ModRM and 84 immediate vectors, then the burst
	localparam int STREAM_LEN = 40;
	localparam int NUM_VECTORS = 42 + 5 + 25 + 84 + STREAM_LEN;
	localparam int CYCLE_LIMIT = NUM_VECTORS * 4 + 200;

	logic           clk;
	logic           arst_n;
	logic           in_valid;
	logic           in_ready;
	window_t        in_window;
	logic           out_valid;
	logic           out_ready;
	predec_result_t out_result;
	int             cycles;

	x86_predec_top dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_window  (in_window),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display(">>> FAIL");
		$fatal(1);
	end

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	// One window through an idle pipeline with out_ready high
	task automatic apply_window(input window_t w, output predec_result_t r);
		@(negedge clk);
		in_valid = 1'b1;
		in_window = w;
		#1;
		while (!in_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		in_valid = 1'b0;
		#1;
		compare("out_valid one cycle after accept", out_valid, 1'b0);
		@(negedge clk);
		#1;
		compare("out_valid two cycles after accept", out_valid, 1'b1);
		r = out_result;
	endtask

`include "tb_x86_predec_tests.svh"

	initial begin
		void'($urandom(83));
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_window = '0;
		out_ready = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		prefix_chains();
		escape_handling();
		modrm_decode();
		immediate_table();
		stream_backpressure();
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
x86_predec_pkg.sv
prefix_scan.sv
opcode_locate.sv
opcode_tables.sv
modrm_fields.sv
x86_predec_top.sv
x86_predec_sva.sv
tb_x86_predec.sv

// ==== Bender.yml ====
package:
  name: x86_predec

export_include_dirs:
  - .

sources:
  - x86_predec_pkg.sv
  - prefix_scan.sv
  - opcode_locate.sv
  - opcode_tables.sv
  - modrm_fields.sv
  - x86_predec_top.sv
  - target: test
    files:
      - x86_predec_sva.sv
      - tb_x86_predec.sv
